//--- Bender.yml
package:
  name: dc_tag

sources:
  - files:
      - dc_pkg.sv
      - dc_if.sv
      - dc_req_decoder.sv
      - dc_tag_store.sv
      - dc_tag_update.sv
      - dc_tag_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_dc_tag.sv

//--- dc_if.sv
// Lookup interface from the decoder and tag read/write interface of the store.
`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// Registered request, shared by all three blocks
////////////////////////////////////////////////////////////

interface dc_lookup_if;

  logic                             valid;     // Request in the lookup stage.
  logic [dc_pkg::index_width-1:0]   index;     // Set being looked up.
  logic [dc_pkg::tag_width-1:0]     tag;       // Tag to compare against both ways.
  logic                             is_write;  // Request is a store.

  // The decoder owns every signal of the stage.
  modport decoder (
    output valid,
    output index,
    output tag,
    output is_write
  );

  // The store only needs the set to read and to write.
  modport store (
    input  index
  );

  // The update unit consumes the whole request.
  modport update (
    input  valid,
    input  index,
    input  tag,
    input  is_write
  );

endinterface

////////////////////////////////////////////////////////////
// Tag array read data and write back data
////////////////////////////////////////////////////////////

interface dc_tag_if;

  dc_pkg::tag_entry_t data_out_way1;  // Entry of way1 at the current index.
  dc_pkg::tag_entry_t data_out_way2;  // Entry of way2 at the current index.
  logic               wr;             // Write both ways at the next edge.
  dc_pkg::tag_entry_t data_in_way1;   // New entry for way1.
  dc_pkg::tag_entry_t data_in_way2;   // New entry for way2.

  modport store (
    output data_out_way1,
    output data_out_way2,
    input  wr,
    input  data_in_way1,
    input  data_in_way2
  );

  modport update (
    input  data_out_way1,
    input  data_out_way2,
    output wr,
    output data_in_way1,
    output data_in_way2
  );

endinterface

//--- dc_pkg.sv
// Address field widths, cache geometry, tag entry union and the way encoding.
package dc_pkg;

  ////////////////////////////////////////////////////////////
  // Request address split
  ////////////////////////////////////////////////////////////

  localparam int addr_width   = 20;  // Byte address carried by a request.
  localparam int tag_width    = 14;  // Upper address bits kept in the tag store.
  localparam int index_width  = 4;   // Set select bits.
  localparam int offset_width = 2;   // Byte offset inside a line, unused here.

  ////////////////////////////////////////////////////////////
  // Cache geometry
  ////////////////////////////////////////////////////////////

  localparam int num_sets    = 16;             // One tag entry per way per set.
  localparam int entry_width = 2 + tag_width;  // Valid bit, dirty bit and tag.

  // Field view of one tag entry, valid bit at the top of the word.
  typedef struct packed {
    logic                 valid;  // Entry holds a line.
    logic                 dirty;  // Line was written since it was filled.
    logic [tag_width-1:0] tag;    // Address tag of the line.
  } tag_fields_t;

  // One stored word seen either as it sits in the array or split into fields.
  typedef union packed {
    logic [entry_width-1:0] raw;     // Word as held by the tag store.
    tag_fields_t            fields;  // Decoded view for compare and update.
  } tag_entry_t;

  ////////////////////////////////////////////////////////////
  // Response encoding
  ////////////////////////////////////////////////////////////

  // Names the hit way or the victim way of a set.
  typedef enum logic {
    way1 = 1'b0,  // First way, also the reset choice of every LRU bit.
    way2 = 1'b1   // Second way.
  } way_t;

endpackage

//--- dc_req_decoder.sv
// Request decoder: registers the request strobe and splits the address.
`timescale 1ns/1ps

module dc_req_decoder (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          req_valid,  // One-cycle request strobe.
  input  logic [dc_pkg::addr_width-1:0] req_addr,   // Byte address of the request.
  input  logic                          req_write,  // High for a store.
  dc_lookup_if.decoder                  lookup
);

  ////////////////////////////////////////////////////////////
  // Address fields
  ////////////////////////////////////////////////////////////

  logic [dc_pkg::tag_width-1:0]   addr_tag;    // Upper bits of the address.
  logic [dc_pkg::index_width-1:0] addr_index;  // Set select bits above the offset.

  assign addr_tag   = req_addr[dc_pkg::addr_width-1 -: dc_pkg::tag_width];    // Top bits.
  assign addr_index = req_addr[dc_pkg::offset_width +: dc_pkg::index_width];  // Skip offset.

  ////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////

  // The strobe is the only control bit of the stage.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lookup.valid <= 1'b0;  // Stage empty after reset.
    end else begin
      lookup.valid <= req_valid;  // A new request may arrive every cycle.
    end
  end

  // Payload only moves when a request is taken, so it holds between requests.
  always_ff @(posedge clk) begin
    if (req_valid) begin
      lookup.tag      <= addr_tag;    // Tag for the compare.
      lookup.index    <= addr_index;  // Set for the array read.
      lookup.is_write <= req_write;   // Read or write flag.
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // The write flag of a request in the stage must stay put until the next request.
  a_write_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    $changed(lookup.is_write) |-> lookup.valid
  ) else $error("dc_req_decoder: is_write changed without a new request.");

endmodule

//--- dc_tag_store.sv
// Two-way tag array with asynchronous read and a clocked write of both ways.
`timescale 1ns/1ps

module dc_tag_store (
  input  logic      clk,
  input  logic      rst_n,
  dc_lookup_if.store lookup,
  dc_tag_if.store    tags
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // One raw word per set in each way.
  logic [dc_pkg::entry_width-1:0] mem_way1 [dc_pkg::num_sets];  // Way1 entries.
  logic [dc_pkg::entry_width-1:0] mem_way2 [dc_pkg::num_sets];  // Way2 entries.

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  // Both ways are read at once, combinationally from the index.
  assign tags.data_out_way1 = dc_pkg::tag_entry_t'(mem_way1[lookup.index]);  // Way1 word.
  assign tags.data_out_way2 = dc_pkg::tag_entry_t'(mem_way2[lookup.index]);  // Way2 word.

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  // A write replaces the whole set, both ways in the same edge.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < dc_pkg::num_sets; s++) begin
        mem_way1[s] <= '0;  // Cleared word has the valid bit low.
        mem_way2[s] <= '0;  // Same for the second way.
      end
    end else if (tags.wr) begin
      mem_way1[lookup.index] <= tags.data_in_way1.raw;  // New way1 entry.
      mem_way2[lookup.index] <= tags.data_in_way2.raw;  // Way2 rewritten too.
    end
  end

  // The read above sees this write one edge later, so a request that follows
  // in the next cycle already reads the updated set.

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // A write strobe from the update unit needs a known set from the decoder.
  a_wr_index_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(tags.wr) |-> !$isunknown(lookup.index)
  ) else $error("dc_tag_store: write raised with an unknown index.");

endmodule

//--- dc_tag_top.sv
// Tag pipeline top level: decoder, tag store and tag update unit.
`timescale 1ns/1ps

module dc_tag_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          req_valid,       // One-cycle request strobe.
  input  logic [dc_pkg::addr_width-1:0] req_addr,        // Byte address.
  input  logic                          req_write,       // High for a store.
  output logic                          resp_valid,      // Two cycles after req_valid.
  output logic                          resp_hit,        // Tag found in the set.
  output dc_pkg::way_t                  resp_way,        // Hit or filled way.
  output logic                          resp_evict,      // Dirty line replaced.
  output logic [dc_pkg::tag_width-1:0]  resp_evict_tag   // Tag of the replaced line.
);

  ////////////////////////////////////////////////////////////
  // Internal buses
  ////////////////////////////////////////////////////////////

  dc_lookup_if lookup ();  // Registered request.
  dc_tag_if    tags ();    // Array read data and write back.

  ////////////////////////////////////////////////////////////
  // Pipeline blocks
  ////////////////////////////////////////////////////////////

  // Stage one: register the request.
  dc_req_decoder u_req_decoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_write (req_write),
    .lookup    (lookup.decoder)
  );

  // Tag array read by the registered index.
  dc_tag_store u_tag_store (
    .clk    (clk),
    .rst_n  (rst_n),
    .lookup (lookup.store),
    .tags   (tags.store)
  );

  // Stage two: compare, update and respond.
  dc_tag_update u_tag_update (
    .clk            (clk),
    .rst_n          (rst_n),
    .lookup         (lookup.update),
    .tags           (tags.update),
    .resp_valid     (resp_valid),
    .resp_hit       (resp_hit),
    .resp_way       (resp_way),
    .resp_evict     (resp_evict),
    .resp_evict_tag (resp_evict_tag)
  );

endmodule

//--- dc_tag_update.sv
// Tag update unit: compare, LRU state, victim choice, entry write back and response.
`timescale 1ns/1ps

module dc_tag_update (
  input  logic                         clk,
  input  logic                         rst_n,
  dc_lookup_if.update                  lookup,
  dc_tag_if.update                     tags,
  output logic                         resp_valid,      // Response strobe.
  output logic                         resp_hit,        // Request hit in one way.
  output dc_pkg::way_t                 resp_way,        // Hit way or filled way.
  output logic                         resp_evict,      // A dirty line was replaced.
  output logic [dc_pkg::tag_width-1:0] resp_evict_tag   // Tag of the replaced line.
);

  ////////////////////////////////////////////////////////////
  // Tag compare
  ////////////////////////////////////////////////////////////

  dc_pkg::tag_entry_t entry1;     // Current way1 entry of the set.
  dc_pkg::tag_entry_t entry2;     // Current way2 entry of the set.
  logic               hit_way1;   // Way1 holds the requested tag.
  logic               hit_way2;   // Way2 holds the requested tag.
  logic               hit;        // Either way holds it.

  assign entry1 = tags.data_out_way1;
  assign entry2 = tags.data_out_way2;

  assign hit_way1 = entry1.fields.valid && (entry1.fields.tag == lookup.tag);  // Valid match.
  assign hit_way2 = entry2.fields.valid && (entry2.fields.tag == lookup.tag);  // Valid match.
  assign hit      = hit_way1 || hit_way2;

  ////////////////////////////////////////////////////////////
  // LRU state and victim choice
  ////////////////////////////////////////////////////////////

  logic [dc_pkg::num_sets-1:0] lru;           // Per set, the way to replace next.
  dc_pkg::way_t                victim_way;    // Way a miss would fill.
  dc_pkg::way_t                access_way;    // Way this request touches.
  dc_pkg::tag_entry_t          victim_entry;  // Entry that a miss replaces.
  dc_pkg::tag_entry_t          access_entry;  // Entry that this request touches.
  dc_pkg::tag_entry_t          new_entry;     // Entry written into the touched way.
  logic                        evict;         // Victim was valid and dirty.

  always_comb begin
    // Empty ways fill first, way1 ahead of way2, then the LRU bit decides.
    if (!entry1.fields.valid) begin
      victim_way = dc_pkg::way1;
    end else if (!entry2.fields.valid) begin
      victim_way = dc_pkg::way2;
    end else begin
      victim_way = dc_pkg::way_t'(lru[lookup.index]);
    end

    victim_entry = (victim_way == dc_pkg::way1) ? entry1 : entry2;  // Line at risk.

    // A hit touches the matching way, a miss touches the victim.
    if (hit) begin
      access_way = hit_way2 ? dc_pkg::way2 : dc_pkg::way1;
    end else begin
      access_way = victim_way;
    end

    access_entry = (access_way == dc_pkg::way1) ? entry1 : entry2;

    // Only a miss can push a modified line out.
    evict = !hit && victim_entry.fields.valid && victim_entry.fields.dirty;

    // Touched way becomes valid with the request tag.
    new_entry.fields.valid = 1'b1;
    new_entry.fields.tag   = lookup.tag;
    if (hit) begin
      new_entry.fields.dirty = access_entry.fields.dirty | lookup.is_write;  // Keeps old dirt.
    end else begin
      new_entry.fields.dirty = lookup.is_write;  // Fresh line is clean unless written.
    end
  end

  ////////////////////////////////////////////////////////////
  // Entry write back
  ////////////////////////////////////////////////////////////

  // Every request rewrites its set, the untouched way with its old word.
  assign tags.wr           = lookup.valid;
  assign tags.data_in_way1 = (access_way == dc_pkg::way1) ? new_entry : entry1;
  assign tags.data_in_way2 = (access_way == dc_pkg::way2) ? new_entry : entry2;

  // The LRU bit points away from the way just used.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lru <= '0;  // All sets pick way1 first.
    end else if (lookup.valid) begin
      lru[lookup.index] <= (access_way == dc_pkg::way1) ? 1'b1 : 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;  // No response pending.
    end else begin
      resp_valid <= lookup.valid;  // Two cycles after the request strobe.
    end
  end

  // Result fields are only meaningful while resp_valid is high.
  always_ff @(posedge clk) begin
    if (lookup.valid) begin
      resp_hit       <= hit;
      resp_way       <= access_way;
      resp_evict     <= evict;
      resp_evict_tag <= victim_entry.fields.tag;  // Victim tag, dirty or not.
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // The same tag must never sit in both ways of a set.
  a_single_hit : assert property (
    @(posedge clk) disable iff (!rst_n)
    lookup.valid |-> !(hit_way1 && hit_way2)
  ) else $error("dc_tag_update: tag found in both ways of set %0d.", lookup.index);

endmodule

//--- tb_clk_gen.sv
// Testbench clock source with a 4 ns period.
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk  // Free running clock, low at time zero.
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // Half period of 2 ns.
  end

endmodule

//--- tb_dc_tag.sv
// Testbench for the tag pipeline: reference model, stimulus, compare tasks and checker.
`timescale 1ns/1ps

module tb_dc_tag;

  // One expected response, with the cycle in which it must show up.
  typedef struct {
    logic                         hit;
    dc_pkg::way_t                 way;
    logic                         evict;
    logic [dc_pkg::tag_width-1:0] evict_tag;
    int                           due_cycle;
  } expect_t;

  logic                          clk;
  logic                          rst_n;
  logic                          req_valid;
  logic [dc_pkg::addr_width-1:0] req_addr;
  logic                          req_write;
  logic                          resp_valid;
  logic                          resp_hit;
  dc_pkg::way_t                  resp_way;
  logic                          resp_evict;
  logic [dc_pkg::tag_width-1:0]  resp_evict_tag;

  expect_t expect_q [$];   // Responses still owed by the DUT, oldest first.
  expect_t cur;            // Entry under compare in the checker.
  int      cycle_count;    // Rising edges since time zero.

  // Model state, index 0 is way1 and index 1 is way2.
  logic                         model_valid [2][dc_pkg::num_sets];
  logic                         model_dirty [2][dc_pkg::num_sets];
  logic [dc_pkg::tag_width-1:0] model_tag   [2][dc_pkg::num_sets];
  logic                         model_lru   [dc_pkg::num_sets];  // Way index of next victim.

  tb_clk_gen u_clk_gen (.clk(clk));

  dc_tag_top uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req_addr       (req_addr),
    .req_write      (req_write),
    .resp_valid     (resp_valid),
    .resp_hit       (resp_hit),
    .resp_way       (resp_way),
    .resp_evict     (resp_evict),
    .resp_evict_tag (resp_evict_tag)
  );

  always @(posedge clk) cycle_count <= cycle_count + 1;  // Edge counter for latency checks.

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  task automatic clear_model();
    for (int s = 0; s < dc_pkg::num_sets; s++) begin
      model_valid[0][s] = 1'b0;  // Every line is empty after reset.
      model_valid[1][s] = 1'b0;
      model_dirty[0][s] = 1'b0;
      model_dirty[1][s] = 1'b0;
      model_tag[0][s]   = '0;
      model_tag[1][s]   = '0;
      model_lru[s]      = 1'b0;  // Way1 is replaced first.
    end
  endtask

  // Applies one access to the model and returns what the DUT must answer.
  function automatic expect_t model_access(input logic [dc_pkg::addr_width-1:0] addr,
                                           input logic                          write);
    logic [dc_pkg::tag_width-1:0] tag;
    int                           set;
    int                           used;
    expect_t                      res;
    tag           = addr >> (dc_pkg::offset_width + dc_pkg::index_width);
    set           = (addr >> dc_pkg::offset_width) % dc_pkg::num_sets;
    used          = 0;
    res.hit       = 1'b0;
    res.evict     = 1'b0;
    res.evict_tag = '0;
    for (int w = 0; w < 2; w++) begin
      if (model_valid[w][set] && model_tag[w][set] == tag) begin
        res.hit = 1'b1;  // A line holding this tag exists.
        used    = w;
      end
    end
    if (res.hit) begin
      model_dirty[used][set] = model_dirty[used][set] | write;  // Stays dirty once written.
    end else begin
      if (!model_valid[0][set]) used = 0;       // Empty way1 fills first.
      else if (!model_valid[1][set]) used = 1;  // Then an empty way2.
      else used = model_lru[set];               // Else the least recently used way.
      res.evict              = model_valid[used][set] && model_dirty[used][set];
      res.evict_tag          = model_tag[used][set];
      model_valid[used][set] = 1'b1;
      model_tag[used][set]   = tag;
      model_dirty[used][set] = write;  // A new line is dirty only when written.
    end
    model_lru[set] = (used == 0);  // Next victim is the other way.
    res.way        = (used == 0) ? dc_pkg::way1 : dc_pkg::way2;
    res.due_cycle  = cycle_count + 2;  // Seen after the second rising edge.
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_hit(input logic got, input logic want, input string what);
    if (got !== want) begin
      $display("FAILED at %0t ns: %s expected %0b, got %0b", $time, what, want, got);
      abort_run();
    end
  endtask

  task automatic check_way(input dc_pkg::way_t got, input dc_pkg::way_t want, input string what);
    if (got !== want) begin
      $display("FAILED at %0t ns: %s expected way%0d, got %0b", $time, what, want + 1, got);
      abort_run();
    end
  endtask

  task automatic check_tag(input logic [dc_pkg::tag_width-1:0] got,
                           input logic [dc_pkg::tag_width-1:0] want, input string what);
    if (got !== want) begin
      $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h", $time, what, want, got);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Checker
  ////////////////////////////////////////////////////////////

  // Outputs settle right after the rising edge, so they are sampled at the falling edge.
  always @(negedge clk) begin
    if (rst_n === 1'b1 && resp_valid === 1'b1) begin
      if (expect_q.size() == 0) begin
        $display("Unexpected response: resp_valid high at %0t ns with none outstanding", $time);
        abort_run();
      end else begin
        cur = expect_q.pop_front();
        if (cycle_count != cur.due_cycle) begin
          $display("FAILED at %0t ns: response in cycle %0d, expected cycle %0d",
                   $time, cycle_count, cur.due_cycle);
          abort_run();
        end
        check_hit(resp_hit, cur.hit, "resp_hit");
        check_way(resp_way, cur.way, "resp_way");
        check_hit(resp_evict, cur.evict, "resp_evict");
        if (cur.evict) check_tag(resp_evict_tag, cur.evict_tag, "resp_evict_tag");
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;  // Inputs change 1 ns after the edge.
  endtask

  function automatic logic [dc_pkg::addr_width-1:0] make_addr(input int tag, input int set,
                                                             input int offset);
    return {tag[dc_pkg::tag_width-1:0], set[dc_pkg::index_width-1:0],
            offset[dc_pkg::offset_width-1:0]};
  endfunction

  // One-cycle strobe; a following call in the same time step keeps it high.
  task automatic send_request(input logic [dc_pkg::addr_width-1:0] addr, input logic write);
    req_valid = 1'b1;
    req_addr  = addr;
    req_write = write;
    expect_q.push_back(model_access(addr, write));
    next_cycle();
    req_valid = 1'b0;
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (expect_q.size() != 0 && waited < 20) begin
      next_cycle();
      waited++;
    end
    if (expect_q.size() != 0) begin
      $display("Missing response: %0d responses never arrived by %0t ns",
               expect_q.size(), $time);
      abort_run();
    end
  endtask

  task automatic apply_reset();
    rst_n     = 1'b0;
    req_valid = 1'b0;
    repeat (5) @(posedge clk);  // Held for five cycles.
    #1;
    rst_n = 1'b1;
    clear_model();
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    integer      seed;
    logic [31:0] r;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req_addr    = '0;
    req_write   = 1'b0;
    cycle_count = 0;
    clear_model();
    apply_reset();

    // First read misses into way1, repeats hit, the offset is ignored.
    send_request(make_addr('h123, 3, 0), 1'b0);
    next_cycle();
    next_cycle();
    send_request(make_addr('h123, 3, 0), 1'b0);
    next_cycle();
    send_request(make_addr('h123, 3, 2), 1'b0);
    wait_for_drain();

    // Fill way2, then let LRU pick the victim as accesses move around.
    send_request(make_addr('h200, 5, 0), 1'b0);
    send_request(make_addr('h201, 5, 1), 1'b0);
    send_request(make_addr('h200, 5, 0), 1'b0);
    send_request(make_addr('h202, 5, 3), 1'b0);
    send_request(make_addr('h200, 5, 0), 1'b0);
    send_request(make_addr('h201, 5, 0), 1'b0);
    wait_for_drain();

    // Dirty lines report their tag on eviction, clean ones stay quiet.
    send_request(make_addr('h010, 2, 0), 1'b1);
    send_request(make_addr('h011, 2, 0), 1'b0);
    send_request(make_addr('h012, 2, 0), 1'b0);
    send_request(make_addr('h011, 2, 0), 1'b0);
    send_request(make_addr('h013, 2, 0), 1'b0);
    send_request(make_addr('h013, 2, 1), 1'b1);
    send_request(make_addr('h011, 2, 0), 1'b0);
    send_request(make_addr('h014, 2, 0), 1'b0);
    wait_for_drain();

    // Back to back on one set, each request sees the write of the one before.
    send_request(make_addr('h020, 7, 0), 1'b0);
    send_request(make_addr('h021, 7, 0), 1'b1);
    send_request(make_addr('h020, 7, 0), 1'b1);
    send_request(make_addr('h022, 7, 0), 1'b0);
    send_request(make_addr('h021, 7, 0), 1'b0);
    send_request(make_addr('h020, 7, 0), 1'b0);
    send_request(make_addr('h023, 7, 0), 1'b1);
    send_request(make_addr('h022, 7, 0), 1'b0);
    wait_for_drain();

    // A reset mid run empties the array, so known lines miss again.
    apply_reset();
    send_request(make_addr('h123, 3, 0), 1'b0);
    send_request(make_addr('h200, 5, 0), 1'b0);
    send_request(make_addr('h020, 7, 0), 1'b0);
    wait_for_drain();

    // Random stream over four sets and eight tags with idle gaps.
    seed = 32'h2804;
    for (int i = 0; i < 400; i++) begin
      r = $random(seed);
      if (r[10:8] == 3'd0) next_cycle();  // Occasional bubble.
      send_request(make_addr('h2a0 + r[4:2], r[6:5], r[12:11]), r[7]);
    end
    wait_for_drain();

    $display("All tests passed");
    $finish;
  end

endmodule

//--- vlog.f
dc_pkg.sv
dc_if.sv
dc_req_decoder.sv
dc_tag_store.sv
dc_tag_update.sv
dc_tag_top.sv
tb_clk_gen.sv
tb_dc_tag.sv
